// File: build.f
+incdir+logic
logic/lsu_pkg.sv
logic/ex_stage.sv
logic/mem_stage.sv
logic/wb_stage.sv
logic/data_sram.sv
logic/lsu_pipe_top.sv
verification/lsu_pipe_assertions.sv
verification/lsu_pipe_tb.sv

// File: logic/data_sram.sv
`include "lsu_settings.svh"

module data_sram (
    input  logic                   clk,
    input  logic                   en,
    input  logic                   we,
    input  logic [3:0]             wstrb,
    input  logic [`LSU_RAM_AW-1:0] addr,
    input  logic [31:0]            wdata,
    output logic [31:0]            rdata
);

    logic [31:0] ram [0:(1 << `LSU_RAM_AW)-1];

    // byte writes, strobe bit i covers wdata[8*i +: 8]
    always_ff @(posedge clk) begin
        if (en && we) begin
            for (int i = 0; i < 4; i++) begin
                if (wstrb[i]) begin
                    ram[addr][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    // registered read port
    // keeps its last value on idle cycles and on writes
    always_ff @(posedge clk) begin
        if (en && !we) begin
            rdata <= ram[addr];
        end
    end

endmodule

// File: logic/ex_stage.sv
`include "lsu_settings.svh"

module ex_stage import lsu_pkg::*; (
    input  logic                     clk,
    input  logic                     resetn,
    // from the testbench side
    input  logic                     in_valid,
    output logic                     in_allowin,
    input  logic [31:0]              in_pc,
    input  lsu_op_e                  in_op,
    input  logic [31:0]              in_base,
    input  logic [31:0]              in_offset,
    input  logic [31:0]              in_rkd,
    input  logic [4:0]               in_rd,
    // to mem
    input  logic                     mem_allowin,
    output logic                     ex_to_mem_valid,
    output logic [`LSU_EX_MEM_W-1:0] ex_to_mem_bus,
    // data sram request
    output logic                     data_sram_en,
    output logic                     data_sram_we,
    output logic [3:0]               data_sram_wstrb,
    output logic [`LSU_RAM_AW-1:0]   data_sram_addr,
    output logic [31:0]              data_sram_wdata
);

    logic        ex_valid;
    logic [31:0] ex_pc;
    lsu_op_e     ex_op;
    logic [31:0] ex_base;
    logic [31:0] ex_offset;
    logic [31:0] ex_rkd;
    logic [4:0]  ex_rd;

    logic        is_load;
    logic        is_store;
    logic        is_byte;
    logic        is_half;
    logic        is_unsigned;
    logic        ex_rf_we;
    logic        mem_req;
    logic [31:0] ex_sum;
    logic [3:0]  st_strb;
    sram_word_u  st_word;

    assign in_allowin      = ~ex_valid | mem_allowin;   // fixed latency, never waits
    assign ex_to_mem_valid = ex_valid;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ex_valid <= 1'b0;
        end else if (in_allowin) begin
            ex_valid <= in_valid;
        end
    end

    // payload, only loaded on a transfer
    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            ex_pc     <= in_pc;
            ex_op     <= in_op;
            ex_base   <= in_base;
            ex_offset <= in_offset;
            ex_rkd    <= in_rkd;
            ex_rd     <= in_rd;
        end
    end

    assign is_load     = ex_op inside {op_ld_b, op_ld_h, op_ld_w, op_ld_bu, op_ld_hu};
    assign is_store    = ex_op inside {op_st_b, op_st_h, op_st_w};
    assign is_byte     = ex_op inside {op_ld_b, op_ld_bu, op_st_b};
    assign is_half     = ex_op inside {op_ld_h, op_ld_hu, op_st_h};
    assign is_unsigned = ex_op inside {op_ld_bu, op_ld_hu};
    assign ex_rf_we    = ~is_store;  // alu and loads write rd

    assign ex_sum = ex_base + ex_offset;   // alu result or byte address

    // lane replication, the strobe picks the lane that lands
    always_comb begin
        st_word.word = ex_rkd;
        if (is_byte) begin
            st_word.lane = {4{ex_rkd[7:0]}};
        end else if (is_half) begin
            st_word.half = {2{ex_rkd[15:0]}};
        end
    end

    always_comb begin
        if (is_byte) begin
            st_strb = 4'b0001 << ex_sum[1:0];
        end else if (is_half) begin
            st_strb = ex_sum[1] ? 4'b1100 : 4'b0011;
        end else begin
            st_strb = 4'b1111;
        end
    end

    // request only in the cycle the op moves into mem
    assign mem_req         = ex_valid & mem_allowin;
    assign data_sram_en    = mem_req & (is_load | is_store);
    assign data_sram_we    = mem_req & is_store;
    assign data_sram_wstrb = data_sram_we ? st_strb : 4'b0000;
    assign data_sram_addr  = ex_sum[`LSU_RAM_AW+1:2];   // word address
    assign data_sram_wdata = st_word.word;

    assign ex_to_mem_bus = {ex_pc,         // 32
                            is_load,       // res_from_mem
                            ex_rf_we,
                            ex_rd,         // 5
                            ex_sum,        // 32
                            ex_sum[1:0],   // byte offset for lane select
                            is_byte,
                            is_half,
                            is_unsigned};
endmodule

// File: logic/lsu_pipe_top.sv
`include "lsu_settings.svh"

module lsu_pipe_top import lsu_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    // instruction in
    input  logic        in_valid,
    output logic        in_allowin,
    input  logic [31:0] in_pc,
    input  lsu_op_e     in_op,
    input  logic [31:0] in_base,
    input  logic [31:0] in_offset,
    input  logic [31:0] in_rkd,
    input  logic [4:0]  in_rd,
    // retire out
    input  logic        out_ready,
    output logic        debug_wb_valid,
    output logic [31:0] debug_wb_pc,
    output logic        debug_wb_rf_we,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);

    logic                     mem_allowin;
    logic                     wb_allowin;
    logic                     ex_to_mem_valid;
    logic [`LSU_EX_MEM_W-1:0] ex_to_mem_bus;
    logic                     mem_to_wb_valid;
    logic [`LSU_MEM_WB_W-1:0] mem_to_wb_bus;

    logic                     data_sram_en;
    logic                     data_sram_we;
    logic [3:0]               data_sram_wstrb;
    logic [`LSU_RAM_AW-1:0]   data_sram_addr;
    logic [31:0]              data_sram_wdata;
    logic [31:0]              data_sram_rdata;

    ex_stage ex_stage_i (
        .clk             (clk),
        .resetn          (resetn),
        .in_valid        (in_valid),
        .in_allowin      (in_allowin),
        .in_pc           (in_pc),
        .in_op           (in_op),
        .in_base         (in_base),
        .in_offset       (in_offset),
        .in_rkd          (in_rkd),
        .in_rd           (in_rd),
        .mem_allowin     (mem_allowin),
        .ex_to_mem_valid (ex_to_mem_valid),
        .ex_to_mem_bus   (ex_to_mem_bus),
        .data_sram_en    (data_sram_en),
        .data_sram_we    (data_sram_we),
        .data_sram_wstrb (data_sram_wstrb),
        .data_sram_addr  (data_sram_addr),
        .data_sram_wdata (data_sram_wdata)
    );

    mem_stage mem_stage_i (
        .clk             (clk),
        .resetn          (resetn),
        .mem_allowin     (mem_allowin),
        .ex_to_mem_valid (ex_to_mem_valid),
        .ex_to_mem_bus   (ex_to_mem_bus),
        .wb_allowin      (wb_allowin),
        .mem_to_wb_valid (mem_to_wb_valid),
        .mem_to_wb_bus   (mem_to_wb_bus),
        .data_sram_rdata (data_sram_rdata)
    );

    wb_stage wb_stage_i (
        .clk               (clk),
        .resetn            (resetn),
        .wb_allowin        (wb_allowin),
        .mem_to_wb_valid   (mem_to_wb_valid),
        .mem_to_wb_bus     (mem_to_wb_bus),
        .out_ready         (out_ready),
        .debug_wb_valid    (debug_wb_valid),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    data_sram data_sram_i (
        .clk   (clk),
        .en    (data_sram_en),
        .we    (data_sram_we),
        .wstrb (data_sram_wstrb),
        .addr  (data_sram_addr),
        .wdata (data_sram_wdata),
        .rdata (data_sram_rdata)
    );

endmodule

// File: logic/lsu_pkg.sv
package lsu_pkg;

    // operation select coming in with each instruction
    // loads and stores are grouped so that size and sign
    // fall out of simple set membership in ex
    typedef enum logic [3:0] {
        op_alu   = 4'd0,   // rd = base + offset
        op_ld_b  = 4'd1,
        op_ld_h  = 4'd2,
        op_ld_w  = 4'd3,
        op_ld_bu = 4'd4,
        op_ld_hu = 4'd5,
        op_st_b  = 4'd6,
        op_st_h  = 4'd7,
        op_st_w  = 4'd8
    } lsu_op_e;

    // one sram word, three views of the same 32 bits
    // half[0] / lane[0] are the least significant
    typedef union packed {
        logic [31:0]       word;
        logic [1:0][15:0]  half;   // selected by addr[1]
        logic [3:0][7:0]   lane;   // selected by addr[1:0]
    } sram_word_u;

endpackage

// File: logic/lsu_settings.svh
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// data sram geometry
// word address bits, 256 words of 32 bits
`define LSU_RAM_AW 8

// stage bus widths

// ex -> mem
// {pc[31:0], res_from_mem, rf_we, rd[4:0], alu_result[31:0],
//  addr_lo[1:0], is_byte, is_half, is_unsigned}
// 32 + 1 + 1 + 5 + 32 + 2 + 3
`define LSU_EX_MEM_W 76

// mem -> wb
// {rf_we, rd[4:0], wdata[31:0], pc[31:0]}
// 1 + 5 + 32 + 32
`define LSU_MEM_WB_W 70

`endif

// File: logic/mem_stage.sv
`include "lsu_settings.svh"

module mem_stage import lsu_pkg::*; (
    input  logic                     clk,
    input  logic                     resetn,
    // ex side
    output logic                     mem_allowin,
    input  logic                     ex_to_mem_valid,
    input  logic [`LSU_EX_MEM_W-1:0] ex_to_mem_bus,
    // wb side
    input  logic                     wb_allowin,
    output logic                     mem_to_wb_valid,
    output logic [`LSU_MEM_WB_W-1:0] mem_to_wb_bus,   // {rf_we, rd, wdata, pc}
    // read data, one cycle after the request issued by ex
    input  logic [31:0]              data_sram_rdata
);

    logic        mem_valid;
    logic [31:0] mem_pc;
    logic        mem_res_from_mem;   // load
    logic        mem_rf_we;
    logic [4:0]  mem_rd;
    logic [31:0] mem_alu_result;
    logic [1:0]  mem_addr_lo;
    logic        mem_is_byte;
    logic        mem_is_half;
    logic        mem_is_unsigned;

    sram_word_u  rd_word;
    logic [7:0]  ld_byte;
    logic [15:0] ld_half;
    logic [31:0] ld_result;
    logic [31:0] mem_rf_wdata;

    assign mem_allowin     = ~mem_valid | wb_allowin;   // read data is always there in time
    assign mem_to_wb_valid = mem_valid;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mem_valid <= 1'b0;
        end else if (mem_allowin) begin
            mem_valid <= ex_to_mem_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_to_mem_valid && mem_allowin) begin
            {mem_pc, mem_res_from_mem, mem_rf_we, mem_rd,
             mem_alu_result, mem_addr_lo,
             mem_is_byte, mem_is_half, mem_is_unsigned} <= ex_to_mem_bus;
        end
    end

    // sram output is held while we stall, ex sends nothing new
    assign rd_word.word = data_sram_rdata;
    assign ld_byte      = rd_word.lane[mem_addr_lo];
    assign ld_half      = rd_word.half[mem_addr_lo[1]];

    always_comb begin
        if (mem_is_byte) begin
            ld_result = {{24{~mem_is_unsigned & ld_byte[7]}}, ld_byte};
        end else if (mem_is_half) begin
            ld_result = {{16{~mem_is_unsigned & ld_half[15]}}, ld_half};
        end else begin
            ld_result = rd_word.word;
        end
    end

    assign mem_rf_wdata = mem_res_from_mem ? ld_result : mem_alu_result;

    assign mem_to_wb_bus = {mem_rf_we & mem_valid,   // 1
                            mem_rd,                  // 5
                            mem_rf_wdata,            // 32
                            mem_pc};                 // 32
endmodule

// File: logic/wb_stage.sv
`include "lsu_settings.svh"

module wb_stage (
    input  logic                     clk,
    input  logic                     resetn,
    // mem side
    output logic                     wb_allowin,
    input  logic                     mem_to_wb_valid,
    input  logic [`LSU_MEM_WB_W-1:0] mem_to_wb_bus,
    // retire port
    input  logic                     out_ready,
    output logic                     debug_wb_valid,
    output logic [31:0]              debug_wb_pc,
    output logic                     debug_wb_rf_we,
    output logic [4:0]               debug_wb_rf_wnum,
    output logic [31:0]              debug_wb_rf_wdata
);

    logic        wb_valid;
    logic        wb_ready_go;
    logic        wb_rf_we;
    logic [4:0]  wb_rd;
    logic [31:0] wb_wdata;
    logic [31:0] wb_pc;

    // retiring is the only way out, so out_ready is the go signal
    assign wb_ready_go = out_ready;
    assign wb_allowin  = ~wb_valid | wb_ready_go;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_valid <= 1'b0;
        end else if (wb_allowin) begin
            wb_valid <= mem_to_wb_valid;
        end
    end

    // held while out_ready is low, so the debug fields stay put
    always_ff @(posedge clk) begin
        if (mem_to_wb_valid && wb_allowin) begin
            {wb_rf_we, wb_rd, wb_wdata, wb_pc} <= mem_to_wb_bus;
        end
    end

    assign debug_wb_valid    = wb_valid;
    assign debug_wb_pc       = wb_pc;
    assign debug_wb_rf_we    = wb_rf_we & wb_valid;   // low for stores
    assign debug_wb_rf_wnum  = wb_rd;
    assign debug_wb_rf_wdata = wb_wdata;

endmodule

// File: run.sh
#!/bin/sh
# build with verilator, run, then look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module lsu_pipe_tb -f build.f -o lsu_pipe_sim \
    && ./obj_dir/lsu_pipe_sim +verilator+error+limit+1000 2>&1 | tee sim.log \
    && grep -qx "Regression passed" sim.log \
    && echo "simulation ok" \
    || { echo "simulation not ok, see sim.log"; exit 1; }

// File: verification/lsu_pipe_assertions.sv
module lsu_pipe_assertions (
    input logic        clk,
    input logic        resetn,
    input logic        out_ready,
    input logic        debug_wb_valid,
    input logic [31:0] debug_wb_pc,
    input logic        debug_wb_rf_we,
    input logic [4:0]  debug_wb_rf_wnum,
    input logic [31:0] debug_wb_rf_wdata,
    input logic        data_sram_we,
    input logic [3:0]  data_sram_wstrb
);

    int fail_count = 0;   // read back by the testbench at the end

    // sync reset clears the retire slot one edge later
    wb_idle_in_reset: assert property (@(posedge clk) !resetn |=> !debug_wb_valid)
        else begin
            $error("debug_wb_valid high while in reset");
            fail_count++;
        end

    no_strobe_on_read: assert property (@(posedge clk) disable iff (!resetn)
        !data_sram_we |-> (data_sram_wstrb == 4'b0000))
        else begin
            $error("data_sram_wstrb nonzero without data_sram_we");
            fail_count++;
        end

    // retire port holds its fields until accepted
    retire_held: assert property (@(posedge clk) disable iff (!resetn)
        (debug_wb_valid && !out_ready) |=> (debug_wb_valid && $stable(debug_wb_pc)
        && $stable(debug_wb_rf_we) && $stable(debug_wb_rf_wnum)
        && $stable(debug_wb_rf_wdata)))
        else begin
            $error("debug retire fields changed while stalled");
            fail_count++;
        end

endmodule

bind lsu_pipe_top lsu_pipe_assertions lsu_pipe_assertions_i (
    .clk               (clk),
    .resetn            (resetn),
    .out_ready         (out_ready),
    .debug_wb_valid    (debug_wb_valid),
    .debug_wb_pc       (debug_wb_pc),
    .debug_wb_rf_we    (debug_wb_rf_we),
    .debug_wb_rf_wnum  (debug_wb_rf_wnum),
    .debug_wb_rf_wdata (debug_wb_rf_wdata),
    .data_sram_we      (data_sram_we),
    .data_sram_wstrb   (data_sram_wstrb)
);

// File: verification/lsu_pipe_tb.sv
`include "lsu_settings.svh"

module lsu_pipe_tb import lsu_pkg::*; ();

    localparam int MAX_ROWS  = 32;
    localparam int RST_CYC   = 4;
    localparam int FAST_ROWS = 8;                 // retired with out_ready held high
    localparam int BA        = `LSU_RAM_AW + 2;   // byte address bits

    logic        clk;
    logic        resetn;
    logic        in_valid;
    logic        in_allowin;
    logic [31:0] in_pc;
    lsu_op_e     in_op;
    logic [31:0] in_base;
    logic [31:0] in_offset;
    logic [31:0] in_rkd;
    logic [4:0]  in_rd;
    logic        out_ready;
    logic        debug_wb_valid;
    logic [31:0] debug_wb_pc;
    logic        debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    // stimulus / expectation table
    string       row_name   [0:MAX_ROWS-1];
    lsu_op_e     row_op     [0:MAX_ROWS-1];
    logic [31:0] row_pc     [0:MAX_ROWS-1];
    logic [31:0] row_base   [0:MAX_ROWS-1];
    logic [31:0] row_offset [0:MAX_ROWS-1];
    logic [31:0] row_rkd    [0:MAX_ROWS-1];
    logic [4:0]  row_rd     [0:MAX_ROWS-1];
    logic        row_exp_we [0:MAX_ROWS-1];
    logic [31:0] row_exp_wd [0:MAX_ROWS-1];
    int          row_accept [0:MAX_ROWS-1];
    int          n_rows  = 0;
    int          retired = 0;
    int          cycle   = 0;
    int          checks  = 0;
    int          errors  = 0;
    int          assert_fails;
    integer      seed;
    logic [31:0] rnd;

    logic [7:0]  ref_bytes [0:(1 << BA)-1];   // byte view of the sram

    lsu_pipe_top lsu_pipe_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    task automatic apply_store(input lsu_op_e op, input logic [BA-1:0] a,
                               input logic [31:0] d);
        ref_bytes[a] = d[7:0];
        if (op != op_st_b) begin
            ref_bytes[{a[BA-1:1], 1'b1}] = d[15:8];
        end
        if (op == op_st_w) begin
            ref_bytes[{a[BA-1:2], 2'd2}] = d[23:16];
            ref_bytes[{a[BA-1:2], 2'd3}] = d[31:24];
        end
    endtask

    function automatic logic [31:0] predict_load(input lsu_op_e op, input logic [BA-1:0] a);
        logic [7:0]  b;
        logic [15:0] h;
        b = ref_bytes[a];
        h = {ref_bytes[{a[BA-1:1], 1'b1}], ref_bytes[{a[BA-1:1], 1'b0}]};
        case (op)
            op_ld_b:  return {{24{b[7]}}, b};
            op_ld_bu: return {24'd0, b};
            op_ld_h:  return {{16{h[15]}}, h};
            op_ld_hu: return {16'd0, h};
            default:  return {ref_bytes[{a[BA-1:2], 2'd3}], ref_bytes[{a[BA-1:2], 2'd2}], h};
        endcase
    endfunction

    task automatic add_row(input string name, input lsu_op_e op, input logic [31:0] base,
                           input logic [31:0] offset, input logic [31:0] rkd,
                           input logic [4:0] rd);
        logic [31:0] sum;
        logic        st;
        sum = base + offset;
        st  = op inside {op_st_b, op_st_h, op_st_w};
        row_name[n_rows]   = name;
        row_op[n_rows]     = op;
        row_pc[n_rows]     = 32'h1c00_0000 + 32'(n_rows * 4);
        row_base[n_rows]   = base;
        row_offset[n_rows] = offset;
        row_rkd[n_rows]    = rkd;
        row_rd[n_rows]     = rd;
        row_exp_we[n_rows] = ~st;
        row_exp_wd[n_rows] = (op == op_alu) ? sum : 32'd0;
        if (st) begin
            apply_store(op, sum[BA-1:0], rkd);
        end else if (op != op_alu) begin
            row_exp_wd[n_rows] = predict_load(op, sum[BA-1:0]);
        end
        n_rows++;
    endtask

    task automatic compare(input string test, input string field, input logic [31:0] exp,
                           input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s %s: expected %h, actual %h", test, field, exp, act);
        end
    endtask

    // out_ready high for the latency rows, then random stalls
    initial begin
        seed = 32'h9f1f9d43;
        out_ready = 1'b1;
        forever begin
            @(negedge clk);
            rnd = $random(seed);
            out_ready = (retired < FAST_ROWS) ? 1'b1 : (rnd[0] | rnd[1]);
        end
    end

    // retire checker, in table order
    always @(posedge clk) begin
        if (resetn && debug_wb_valid && out_ready) begin
            if (retired >= n_rows) begin
                errors++;
                $display("unexpected extra retire with pc %h", debug_wb_pc);
            end else begin
                compare(row_name[retired], "pc", row_pc[retired], debug_wb_pc);
                compare(row_name[retired], "rf_we", {31'd0, row_exp_we[retired]},
                        {31'd0, debug_wb_rf_we});
                compare(row_name[retired], "rf_wnum", {27'd0, row_rd[retired]},
                        {27'd0, debug_wb_rf_wnum});
                if (row_exp_we[retired]) begin
                    compare(row_name[retired], "rf_wdata", row_exp_wd[retired],
                            debug_wb_rf_wdata);
                end
                if (retired < FAST_ROWS) begin
                    compare(row_name[retired], "latency", 32'd3,
                            32'(cycle - row_accept[retired]));
                end
                retired++;
            end
        end
    end

    initial begin
        repeat (RST_CYC) @(posedge clk);   // table is complete by now
        repeat (n_rows * 20) @(posedge clk);
        $display("timeout, %0d of %0d instructions retired", retired, n_rows);
        $display("Regression failed");
        $finish;
    end

    initial begin
        resetn    = 1'b0;
        in_valid  = 1'b0;
        in_pc     = 32'd0;
        in_op     = op_alu;
        in_base   = 32'd0;
        in_offset = 32'd0;
        in_rkd    = 32'd0;
        in_rd     = 5'd0;

        add_row("alu_add",     op_alu,   32'h0000_1000, 32'h0000_0234, 32'h0,         5'd1);
        add_row("alu_neg_off", op_alu,   32'h0000_0010, 32'hffff_fff0, 32'h0,         5'd2);
        add_row("alu_wrap",    op_alu,   32'h7fff_ffff, 32'h0000_0001, 32'h0,         5'd3);
        add_row("st_w_base",   op_st_w,  32'h0000_0040, 32'h0000_0000, 32'h1122_3344, 5'd0);
        add_row("st_b_lane1",  op_st_b,  32'h0000_0040, 32'h0000_0001, 32'hdead_bea5, 5'd0);
        add_row("st_h_upper",  op_st_h,  32'h0000_0400, 32'hffff_fc42, 32'h5555_8c7e, 5'd0);
        add_row("ld_w_merged", op_ld_w,  32'h0000_0040, 32'h0000_0000, 32'h0,         5'd4);
        add_row("alu_carry",   op_alu,   32'h8000_0000, 32'h8000_0000, 32'h0,         5'd31);
        add_row("st_w_pat",    op_st_w,  32'h0000_0044, 32'h0000_0000, 32'h80ff_7f01, 5'd0);
        add_row("ld_b_off0",   op_ld_b,  32'h0000_0044, 32'h0000_0000, 32'h0,         5'd5);
        add_row("ld_b_off1",   op_ld_b,  32'h0000_0044, 32'h0000_0001, 32'h0,         5'd6);
        add_row("ld_b_off2",   op_ld_b,  32'h0000_0044, 32'h0000_0002, 32'h0,         5'd7);
        add_row("ld_b_off3",   op_ld_b,  32'h0000_0044, 32'h0000_0003, 32'h0,         5'd8);
        add_row("ld_bu_off2",  op_ld_bu, 32'h0000_0044, 32'h0000_0002, 32'h0,         5'd9);
        add_row("ld_bu_off3",  op_ld_bu, 32'h0000_0040, 32'h0000_0007, 32'h0,         5'd10);
        add_row("ld_bu_off0",  op_ld_bu, 32'h0000_0040, 32'h0000_0000, 32'h0,         5'd11);
        add_row("ld_h_off0",   op_ld_h,  32'h0000_0044, 32'h0000_0000, 32'h0,         5'd12);
        add_row("ld_h_off2",   op_ld_h,  32'h0000_0044, 32'h0000_0002, 32'h0,         5'd13);
        add_row("ld_hu_off2",  op_ld_hu, 32'h0000_0044, 32'h0000_0002, 32'h0,         5'd14);
        add_row("ld_hu_off0",  op_ld_hu, 32'h0000_0040, 32'h0000_0000, 32'h0,         5'd15);
        add_row("ld_h_neg",    op_ld_h,  32'h0000_0040, 32'h0000_0002, 32'h0,         5'd16);
        add_row("st_w_top",    op_st_w,  32'h0000_03fc, 32'h0000_0000, 32'hcafe_f00d, 5'd0);
        add_row("st_b_top",    op_st_b,  32'h0000_03fc, 32'h0000_0003, 32'h0000_0080, 5'd0);
        add_row("ld_w_top",    op_ld_w,  32'h0000_03fc, 32'h0000_0000, 32'h0,         5'd17);
        add_row("st_h_lower",  op_st_h,  32'h0000_0044, 32'h0000_0000, 32'h1234_fedc, 5'd0);
        add_row("ld_w_half",   op_ld_w,  32'h0000_0044, 32'h0000_0000, 32'h0,         5'd18);
        add_row("ld_bu_off1",  op_ld_bu, 32'h0000_0044, 32'h0000_0001, 32'h0,         5'd19);

        repeat (RST_CYC) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        compare("after_reset", "debug_wb_valid", 32'd0, {31'd0, debug_wb_valid});
        compare("after_reset", "in_allowin", 32'd1, {31'd0, in_allowin});

        for (int i = 0; i < n_rows; i++) begin
            @(negedge clk);
            in_valid  = 1'b1;
            in_pc     = row_pc[i];
            in_op     = row_op[i];
            in_base   = row_base[i];
            in_offset = row_offset[i];
            in_rkd    = row_rkd[i];
            in_rd     = row_rd[i];
            @(posedge clk);
            while (!in_allowin) @(posedge clk);   // held until taken
            row_accept[i] = cycle;
        end
        @(negedge clk);
        in_valid = 1'b0;

        wait (retired == n_rows);
        repeat (6) @(posedge clk);   // room for a duplicate to show up
        assert_fails = lsu_pipe_top_i.lsu_pipe_assertions_i.fail_count;
        $display("checks %0d, errors %0d, assertion failures %0d", checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
